//--- Makefile
# Verilator build and run for the pipelined processor testbench

VERILATOR ?= verilator
TOP       ?= proc_tb
FLAGS     ?= --assert
OBJ_DIR   ?= obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' tb.f)
HEADERS := tb/isa_model.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) tb.f
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

# Runs from the project root so prog.hex is found
run: $(BIN) prog.hex
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- design/decode.sv
// Decode stage with register file, control, interlock and ID/EX register, used inside proc
`timescale 1ns/100ps
`default_nettype none

module decode (
  input  wire                  clk,
  input  wire                  arst_n,
  input  proc_pkg::word_t      if_instr,
  input  proc_pkg::word_t      if_pc_next,
  input  proc_pkg::reg_idx_t   ex_rd,
  input  proc_pkg::reg_idx_t   mem_rd,
  input  proc_pkg::reg_idx_t   wb_reg,
  input  logic                 ex_wr_en,
  input  logic                 mem_wr_en,
  input  logic                 wb_en,
  input  logic                 redirect,
  input  proc_pkg::word_t      wb_data,
  output logic                 stall,
  output proc_pkg::opcode_t    id_op,
  output proc_pkg::alu_op_t    id_alu_op,
  output proc_pkg::word_t      id_a,
  output proc_pkg::word_t      id_b,
  output proc_pkg::word_t      id_imm,
  output proc_pkg::word_t      id_pc_next,
  output proc_pkg::reg_idx_t   id_rd,
  output logic                 id_wr_en
);

  import proc_pkg::*;

  opcode_t  op;
  alu_op_t  alu_op;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    imm;
  word_t    rd_a;
  word_t    rd_b;
  logic     wr_en;
  logic     use_a;
  logic     use_b;

  word_t rf [8];

  // Same-cycle writeback is passed straight to the read port
  function automatic word_t rf_read(input reg_idx_t idx);
    if (mem_wr_en && mem_rd == idx) begin
      return wb_data;
    end
    return rf[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (wb_en) begin
      rf[wb_reg] <= wb_data;
    end
  end

  assign op = opcode_t'(if_instr[15:11]);
  assign rs = if_instr[10:8];
  assign rt = if_instr[7:5];

  always_comb begin
    rd_a = rf_read(rs);
    rd_b = rf_read(rt);
  end

  always_comb begin
    alu_op = ALU_PASS;
    rd     = if_instr[7:5];
    imm    = {{11{if_instr[4]}}, if_instr[4:0]};
    wr_en  = 1'b0;
    use_a  = 1'b0;
    use_b  = 1'b0;
    case (op)
      OP_ADDI, OP_LD: begin
        alu_op = ALU_ADD;
        wr_en  = 1'b1;
        use_a  = 1'b1;
      end
      // rt holds the store data
      OP_ST: begin
        alu_op = ALU_ADD;
        use_a  = 1'b1;
        use_b  = 1'b1;
      end
      OP_RTYPE: begin
        rd    = if_instr[4:2];
        wr_en = 1'b1;
        use_a = 1'b1;
        use_b = 1'b1;
        case (if_instr[1:0])
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_XOR:  alu_op = ALU_XOR;
          default: alu_op = ALU_AND;
        endcase
      end
      OP_BEQZ: begin
        imm   = {{8{if_instr[7]}}, if_instr[7:0]};
        use_a = 1'b1;
      end
      OP_J: imm = {{5{if_instr[10]}}, if_instr[10:0]};
      default: ;
    endcase
  end

  // Hold while a source is still being produced in execute or memory
  assign stall = (use_a && ((id_wr_en && id_rd == rs) || (ex_wr_en && ex_rd == rs))) ||
                 (use_b && ((id_wr_en && id_rd == rt) || (ex_wr_en && ex_rd == rt)));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_op     <= OP_NOP;
      id_alu_op <= ALU_PASS;
      id_wr_en  <= 1'b0;
    end else if (stall || redirect) begin
      id_op     <= OP_NOP;
      id_alu_op <= ALU_PASS;
      id_wr_en  <= 1'b0;
    end else begin
      id_op     <= op;
      id_alu_op <= alu_op;
      id_wr_en  <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    id_a       <= rd_a;
    id_b       <= rd_b;
    id_imm     <= imm;
    id_pc_next <= if_pc_next;
    id_rd      <= rd;
  end

  // A stalled instruction must still be waiting in IF/ID afterwards
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (stall && !redirect) |=> ($stable(if_instr) && $stable(if_pc_next)))
    else $error("IF/ID register changed while decode was stalled");

endmodule

`default_nettype wire

//--- design/execute.sv
// Execute stage with ALU, branch resolution, opcode trap and EX/MEM register, used inside proc
`timescale 1ns/100ps
`default_nettype none

module execute (
  input  wire                  clk,
  input  wire                  arst_n,
  input  proc_pkg::opcode_t    id_op,
  input  proc_pkg::alu_op_t    id_alu_op,
  input  proc_pkg::word_t      id_a,
  input  proc_pkg::word_t      id_b,
  input  proc_pkg::word_t      id_imm,
  input  proc_pkg::word_t      id_pc_next,
  input  proc_pkg::reg_idx_t   id_rd,
  input  logic                 id_wr_en,
  output logic                 redirect,
  output proc_pkg::word_t      redirect_pc,
  output proc_pkg::word_t      ex_result,
  output proc_pkg::word_t      ex_store_data,
  output proc_pkg::reg_idx_t   ex_rd,
  output logic                 ex_wr_en,
  output logic                 ex_load,
  output logic                 ex_store,
  output logic                 ex_halt,
  output logic                 err
);

  import proc_pkg::*;

  word_t op_b;
  word_t alu_out;
  logic  legal;
  logic  live;
  logic  halt_seen;

  // Everything behind a HALT is squashed here
  assign live = !halt_seen;
  assign op_b = (id_op == OP_RTYPE) ? id_b : id_imm;

  always_comb begin
    case (id_alu_op)
      ALU_ADD: alu_out = id_a + op_b;
      ALU_SUB: alu_out = id_a - op_b;
      ALU_XOR: alu_out = id_a ^ op_b;
      ALU_AND: alu_out = id_a & op_b;
      default: alu_out = op_b;
    endcase
  end

  always_comb begin
    case (id_op)
      OP_HALT, OP_NOP, OP_ADDI, OP_RTYPE, OP_LD, OP_ST, OP_BEQZ, OP_J: legal = 1'b1;
      default: legal = 1'b0;
    endcase
  end

  assign redirect    = live && ((id_op == OP_BEQZ && id_a == '0) || id_op == OP_J);
  assign redirect_pc = id_pc_next + id_imm;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_wr_en  <= 1'b0;
      ex_load   <= 1'b0;
      ex_store  <= 1'b0;
      ex_halt   <= 1'b0;
      halt_seen <= 1'b0;
      err       <= 1'b0;
    end else begin
      ex_wr_en  <= live && id_wr_en;
      ex_load   <= live && id_op == OP_LD;
      ex_store  <= live && id_op == OP_ST;
      ex_halt   <= live && id_op == OP_HALT;
      halt_seen <= halt_seen || id_op == OP_HALT;
      // Sticky trap
      err       <= err || (live && !legal);
    end
  end

  always_ff @(posedge clk) begin
    ex_result     <= alu_out;
    ex_store_data <= id_b;
    ex_rd         <= id_rd;
  end

  // Both younger instructions reach execute as bubbles after a taken transfer
  a_redirect: assert property (@(posedge clk) disable iff (!arst_n)
    redirect |=> (id_op == OP_NOP && !id_wr_en) ##1 (id_op == OP_NOP && !id_wr_en))
    else $error("younger instructions were not flushed after a redirect");

endmodule

`default_nettype wire

//--- design/fetch.sv
// Fetch stage with the PC, instruction ROM and IF/ID register, instantiated by the processor top
`timescale 1ns/100ps
`default_nettype none

module fetch (
  input  wire             clk,
  input  wire             arst_n,
  input  logic            stall,
  input  logic            redirect,
  input  logic            halted,
  input  proc_pkg::word_t redirect_pc,
  output proc_pkg::word_t if_instr,
  output proc_pkg::word_t if_pc_next
);

  import proc_pkg::*;

  word_t pc;
  word_t pc_plus_2;
  word_t rom_data;
  logic [IMEM_AW-1:0] rom_idx;

  word_t imem [IMEM_WORDS];

  initial begin
    $readmemh(PROG_FILE, imem);
  end

  // Halfword index from the byte address
  assign rom_idx   = pc[IMEM_AW:1];
  assign rom_data  = imem[rom_idx];
  assign pc_plus_2 = pc + 16'd2;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc         <= '0;
      if_instr   <= NOP_INSTR;
      if_pc_next <= '0;
    end else if (redirect) begin
      // Wrong-path instruction becomes a bubble
      pc         <= redirect_pc;
      if_instr   <= NOP_INSTR;
      if_pc_next <= redirect_pc;
    end else if (!stall && !halted) begin
      pc         <= pc_plus_2;
      if_instr   <= rom_data;
      if_pc_next <= pc_plus_2;
    end
  end

endmodule

`default_nettype wire

//--- design/memory_stage.sv
// Memory and writeback stages with data RAM, MEM/WB register and writeback select, used in proc
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
  input  wire                  clk,
  input  wire                  arst_n,
  input  proc_pkg::word_t      ex_result,
  input  proc_pkg::word_t      ex_store_data,
  input  proc_pkg::reg_idx_t   ex_rd,
  input  logic                 ex_wr_en,
  input  logic                 ex_load,
  input  logic                 ex_store,
  input  logic                 ex_halt,
  output proc_pkg::reg_idx_t   mem_rd,
  output logic                 mem_wr_en,
  output logic                 wb_en,
  output proc_pkg::reg_idx_t   wb_reg,
  output proc_pkg::word_t      wb_data,
  output logic                 halted
);

  import proc_pkg::*;

  logic [DMEM_AW-1:0] mem_idx;
  word_t ld_data;
  word_t ld_q;
  word_t res_q;
  logic  wb_load;

  word_t dmem [DMEM_WORDS];

  // Halfword index from the byte address
  assign mem_idx = ex_result[DMEM_AW:1];
  assign ld_data = dmem[mem_idx];

  always_ff @(posedge clk) begin
    if (ex_store) begin
      dmem[mem_idx] <= ex_store_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wr_en <= 1'b0;
      wb_load   <= 1'b0;
      halted    <= 1'b0;
    end else begin
      mem_wr_en <= ex_wr_en;
      wb_load   <= ex_load;
      halted    <= halted || ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd <= ex_rd;
    ld_q   <= ld_data;
    res_q  <= ex_result;
  end

  // Writeback select
  assign wb_en   = mem_wr_en;
  assign wb_reg  = mem_rd;
  assign wb_data = wb_load ? ld_q : res_q;

  // Execute squashes everything younger than HALT
  a_no_commit_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> !wb_en)
    else $error("register write after halt");

endmodule

`default_nettype wire

//--- design/proc.sv
// Processor top level that wires the fetch, decode, execute and memory stages together
`timescale 1ns/100ps
`default_nettype none

module proc (
  input  wire                  clk,
  input  wire                  arst_n,
  output logic                 wb_en,
  output logic                 halted,
  output logic                 err,
  output proc_pkg::reg_idx_t   wb_reg,
  output proc_pkg::word_t      wb_data
);

  import proc_pkg::*;

  // Fetch side
  word_t    if_instr;
  word_t    if_pc_next;
  logic     stall;
  logic     redirect;
  word_t    redirect_pc;

  // Decode to execute
  opcode_t  id_op;
  alu_op_t  id_alu_op;
  word_t    id_a;
  word_t    id_b;
  word_t    id_imm;
  word_t    id_pc_next;
  reg_idx_t id_rd;
  logic     id_wr_en;

  // Execute to memory
  word_t    ex_result;
  word_t    ex_store_data;
  reg_idx_t ex_rd;
  logic     ex_wr_en;
  logic     ex_load;
  logic     ex_store;
  logic     ex_halt;

  // Writeback destination
  reg_idx_t mem_rd;
  logic     mem_wr_en;

  fetch fetch0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .redirect    (redirect),
    .halted      (halted),
    .redirect_pc (redirect_pc),
    .if_instr    (if_instr),
    .if_pc_next  (if_pc_next)
  );

  decode decode0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .if_instr   (if_instr),
    .if_pc_next (if_pc_next),
    .ex_rd      (ex_rd),
    .mem_rd     (mem_rd),
    .wb_reg     (wb_reg),
    .ex_wr_en   (ex_wr_en),
    .mem_wr_en  (mem_wr_en),
    .wb_en      (wb_en),
    .redirect   (redirect),
    .wb_data    (wb_data),
    .stall      (stall),
    .id_op      (id_op),
    .id_alu_op  (id_alu_op),
    .id_a       (id_a),
    .id_b       (id_b),
    .id_imm     (id_imm),
    .id_pc_next (id_pc_next),
    .id_rd      (id_rd),
    .id_wr_en   (id_wr_en)
  );

  execute execute0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .id_op         (id_op),
    .id_alu_op     (id_alu_op),
    .id_a          (id_a),
    .id_b          (id_b),
    .id_imm        (id_imm),
    .id_pc_next    (id_pc_next),
    .id_rd         (id_rd),
    .id_wr_en      (id_wr_en),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .ex_result     (ex_result),
    .ex_store_data (ex_store_data),
    .ex_rd         (ex_rd),
    .ex_wr_en      (ex_wr_en),
    .ex_load       (ex_load),
    .ex_store      (ex_store),
    .ex_halt       (ex_halt),
    .err           (err)
  );

  memory_stage memory0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex_result     (ex_result),
    .ex_store_data (ex_store_data),
    .ex_rd         (ex_rd),
    .ex_wr_en      (ex_wr_en),
    .ex_load       (ex_load),
    .ex_store      (ex_store),
    .ex_halt       (ex_halt),
    .mem_rd        (mem_rd),
    .mem_wr_en     (mem_wr_en),
    .wb_en         (wb_en),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data),
    .halted        (halted)
  );

endmodule

`default_nettype wire

//--- design/proc_pkg.sv
// Shared types, opcodes and memory sizes for the 16-bit pipelined processor; import where needed
`default_nettype none

package proc_pkg;

  // Data, address and instruction word
  typedef logic [15:0] word_t;

  // Index into the eight-entry register file
  typedef logic [2:0] reg_idx_t;

  // Major opcode, instruction bits 15:11
  typedef enum logic [4:0] {
    OP_HALT  = 5'b00000,
    OP_NOP   = 5'b00001,
    OP_J     = 5'b00100,
    OP_ADDI  = 5'b01000,
    OP_BEQZ  = 5'b01100,
    OP_ST    = 5'b10000,
    OP_LD    = 5'b10001,
    OP_RTYPE = 5'b11011
  } opcode_t;

  // Execute-stage operation; SUB is rs minus rt
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_AND,
    ALU_PASS
  } alu_op_t;

  // R-type function field, bits 1:0
  localparam logic [1:0] FN_ADD = 2'b00;
  localparam logic [1:0] FN_SUB = 2'b01;
  localparam logic [1:0] FN_XOR = 2'b10;
  localparam logic [1:0] FN_AND = 2'b11;

  // Bubble injected on stall and flush
  localparam word_t NOP_INSTR = 16'b00001_00000000000;

  localparam int IMEM_WORDS = 256;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // ROM image, also read by the testbench model
  localparam string PROG_FILE = "prog.hex";

endpackage

`default_nettype wire

//--- prog.hex
// One 16-bit instruction per line, address 0 first; text after // names the instruction
// Byte address = 2 * line index
d802 // 00: xor  r0, r0, r0
d926 // 02: xor  r1, r1, r1
4025 // 04: addi r1, r0, 5
4143 // 06: addi r2, r1, 3     distance 1
407e // 08: addi r3, r0, -2
da30 // 0a: add  r4, r2, r1    distances 2 and 3
d975 // 0c: sub  r5, r1, r3
dd9a // 0e: xor  r6, r5, r4
de7f // 10: and  r7, r6, r3
47f0 // 12: addi r7, r7, -16
80c4 // 14: st   r6, 4(r0)
80e6 // 16: st   r7, 6(r0)
8846 // 18: ld   r2, 6(r0)     same address as last store
8824 // 1a: ld   r1, 4(r0)     earlier store
d94c // 1c: add  r3, r1, r2
6004 // 1e: beqz r0, +4        taken
4081 // 20: addi r4, r0, 1     flushed
40a1 // 22: addi r5, r0, 1     flushed
6302 // 24: beqz r3, +2        not taken
4481 // 26: addi r4, r4, 1
2004 // 28: j    +4
40c3 // 2a: addi r6, r0, 3     flushed
40e3 // 2c: addi r7, r0, 3     flushed
44bf // 2e: addi r5, r4, -1
81a0 // 30: st   r5, 0(r1)
88ca // 32: ld   r6, 10(r0)
0000 // 34: halt
4021 // 36: addi r1, r0, 1     must never commit
0800 // 38: nop

//--- tb.f
+incdir+tb
design/proc_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory_stage.sv
design/proc.sv
tb/proc_tb.sv

//--- tb/isa_model.svh
// In-order model of the reduced instruction set; included by the testbench to predict commits
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int MAX_COMMITS = 256;
localparam int MAX_STEPS   = 1000;

// Expected commit stream, filled once at time zero
reg_idx_t exp_reg [MAX_COMMITS];
word_t    exp_val [MAX_COMMITS];
int       exp_count;
int       exec_count;

word_t model_mem  [IMEM_WORDS];
word_t model_regs [8];
word_t model_dmem [DMEM_WORDS];

function automatic void note_commit(input reg_idx_t idx, input word_t value);
  model_regs[idx] = value;
  if (exp_count < MAX_COMMITS) begin
    exp_reg[exp_count] = idx;
    exp_val[exp_count] = value;
    exp_count += 1;
  end
endfunction

function automatic word_t alu_result(input logic [1:0] fn, input word_t a, input word_t b);
  case (fn)
    2'b00:   return a + b;
    2'b01:   return a - b;
    2'b10:   return a ^ b;
    default: return a & b;
  endcase
endfunction

function automatic void run_model();
  word_t    pc;
  word_t    instr;
  word_t    a;
  word_t    b;
  word_t    imm5;
  word_t    addr;
  reg_idx_t rs;
  reg_idx_t rt;
  logic     done;
  $readmemh(PROG_FILE, model_mem);
  for (int i = 0; i < 8; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    model_dmem[i] = '0;
  end
  pc         = '0;
  exp_count  = 0;
  exec_count = 0;
  done       = 1'b0;
  while (!done && exec_count < MAX_STEPS) begin
    instr = model_mem[pc[IMEM_AW:1]];
    rs    = instr[10:8];
    rt    = instr[7:5];
    a     = model_regs[rs];
    b     = model_regs[rt];
    imm5  = {{11{instr[4]}}, instr[4:0]};
    addr  = a + imm5;
    exec_count += 1;
    pc = pc + 16'd2;
    case (instr[15:11])
      OP_HALT:  done = 1'b1;
      OP_NOP:   ;
      OP_ADDI:  note_commit(rt, addr);
      OP_RTYPE: note_commit(instr[4:2], alu_result(instr[1:0], a, b));
      OP_LD:    note_commit(rt, model_dmem[addr[DMEM_AW:1]]);
      OP_ST:    model_dmem[addr[DMEM_AW:1]] = b;
      OP_BEQZ: begin
        if (a == '0) begin
          pc = pc + {{8{instr[7]}}, instr[7:0]};
        end
      end
      OP_J:     pc = pc + {{5{instr[10]}}, instr[10:0]};
      default:  done = 1'b1;
    endcase
  end
endfunction

`endif

//--- tb/proc_tb.sv
// Testbench for the processor that runs prog.hex and checks each commit against the model
`timescale 1ns/100ps
`default_nettype none

module proc_tb;

  import proc_pkg::*;

  `include "isa_model.svh"

  logic     clk;
  logic     arst_n;
  logic     wb_en;
  logic     halted;
  logic     err;
  reg_idx_t wb_reg;
  word_t    wb_data;

  int commit_idx  = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  proc UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .wb_en   (wb_en),
    .halted  (halted),
    .err     (err),
    .wb_reg  (wb_reg),
    .wb_data (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Position in the expected commit stream
  always @(posedge clk) begin
    if (!arst_n) begin
      commit_idx <= 0;
    end else if (wb_en) begin
      commit_idx <= commit_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: program did not halt");
      $display("ERRORS FOUND");
      $fatal(1, "cycle limit reached");
    end
  end

  a_commit: assert property (@(posedge clk) disable iff (!arst_n)
    wb_en |-> (commit_idx < exp_count && wb_reg == exp_reg[commit_idx] &&
               wb_data == exp_val[commit_idx]))
    else begin
      $display("FAILED at %0t: commit %0d wrote r%0d = %h, expected r%0d = %h",
               $time, $sampled(commit_idx), $sampled(wb_reg), $sampled(wb_data),
               exp_reg[$sampled(commit_idx)], exp_val[$sampled(commit_idx)]);
      $display("ERRORS FOUND");
      $fatal(1, "commit mismatch");
    end

  // Outputs quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> (!wb_en && !halted && !err))
    else begin
      $display("wb_en, halted or err was high during reset");
      $display("ERRORS FOUND");
      $fatal(1, "reset state wrong");
    end

  a_no_err: assert property (@(posedge clk) disable iff (!arst_n) !err)
    else begin
      $display("err was raised although the program has only legal opcodes");
      $display("ERRORS FOUND");
      $fatal(1, "unexpected trap");
    end

  a_silent_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> !wb_en)
    else begin
      $display("a register write happened after halted");
      $display("ERRORS FOUND");
      $fatal(1, "commit after halt");
    end

  a_commit_count: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(halted) |-> commit_idx == exp_count)
    else begin
      $display("FAILED at %0t: %0d commits before halt, model expects %0d",
               $time, $sampled(commit_idx), exp_count);
      $display("ERRORS FOUND");
      $fatal(1, "commit count mismatch");
    end

  initial begin
    arst_n = 1'b0;
    run_model();
    // Worst case is a two-cycle stall or a flush on every instruction
    cycle_limit = 4 * exec_count + 20;
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    wait (halted === 1'b1);
    // A few more edges so the halt checks get sampled
    repeat (4) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
